// File: conv_engine.f
+incdir+logic
logic/conv_pkg.sv
logic/conv_controller.sv
logic/conv_mac_array.sv
logic/conv_output_stage.sv
logic/conv_engine.sv
testbench/tb_clock_gen.sv
testbench/conv_engine_tb.sv

// File: logic/conv_controller.sv
`timescale 1ns/100ps
`default_nettype none

`include "conv_settings.svh"

module conv_controller (
    input  wire                 aclk,
    input  wire                 rst,
    input  wire                 start,
    input  wire conv_pkg::conv_cfg_t cfg,
    input  wire                 pixels_valid,
    input  wire                 weights_valid,
    input  wire                 run_done,
    output logic                pixels_ready,
    output logic                weights_ready,
    output logic                beat,
    output conv_pkg::beat_tag_t tag,
    output conv_pkg::conv_cfg_t run_cfg,
    output logic                last_col
);

    typedef enum logic [1:0] {
        IDLE,
        FEED,
        DRAIN
    } state_t;

    state_t                 state;
    logic [1:0]             kpos;
    logic [`CIN_WIDTH-1:0]  ch;
    logic [`COLS_WIDTH-1:0] col;
    logic                   kernel_end;
    logic                   chan_end;

    assign pixels_ready  = (state == FEED);
    // Max mode needs no weights.
    assign weights_ready = (state == FEED) && !run_cfg.is_max;
    assign beat          = pixels_ready && pixels_valid && (run_cfg.is_max || weights_valid);

    assign kernel_end = run_cfg.is_1x1 || (kpos == 2'd2);
    assign chan_end   = (ch == run_cfg.cin_1);
    assign last_col   = (col == run_cfg.cols_1);

    assign tag = '{first: (kpos == 2'd0) && (ch == '0), final_beat: kernel_end && chan_end};

    always_ff @(posedge aclk) begin
        if (rst) begin
            state   <= IDLE;
            run_cfg <= '0;
            kpos    <= '0;
            ch      <= '0;
            col     <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state   <= FEED;
                        run_cfg <= cfg;
                        kpos    <= '0;
                        ch      <= '0;
                        col     <= '0;
                    end
                end
                FEED: begin
                    if (beat) begin
                        if (!kernel_end) begin
                            kpos <= kpos + 2'd1;
                        end else begin
                            kpos <= '0;
                            if (!chan_end) begin
                                ch <= ch + 1'b1;
                            end else begin
                                ch <= '0;
                                // Column complete.
                                if (last_col) begin
                                    state <= DRAIN;
                                end else begin
                                    col <= col + 1'b1;
                                end
                            end
                        end
                    end
                end
                DRAIN: begin
                    // Wait for the last vector to leave the output stage.
                    if (run_done) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    a_no_beat_idle: assert property (@(posedge aclk) disable iff (rst)
        (state == IDLE) |-> !beat)
        else $error("beat accepted while idle");

    a_done_in_drain: assert property (@(posedge aclk) disable iff (rst)
        run_done |-> (state == DRAIN))
        else $error("run_done outside of drain");

endmodule

`default_nettype wire

// File: logic/conv_engine.sv
`timescale 1ns/100ps
`default_nettype none

module conv_engine (
    input  wire                         aclk,
    input  wire                         rst,
    input  wire                         start,
    input  wire conv_pkg::conv_cfg_t    cfg,
    input  wire                         pixels_valid,
    input  wire conv_pkg::pixel_beat_t  pixels,
    output wire                         pixels_ready,
    input  wire                         weights_valid,
    input  wire conv_pkg::weight_beat_t weights,
    output wire                         weights_ready,
    output wire                         m_valid,
    output wire conv_pkg::result_vec_t  m_data,
    output wire                         m_last,
    output wire                         done
);

    import conv_pkg::*;

    wire            beat;
    wire beat_tag_t tag;
    wire conv_cfg_t run_cfg;
    wire            last_col;
    wire acc_vec_t  acc;

    conv_controller u_controller (
        .aclk          (aclk),
        .rst           (rst),
        .start         (start),
        .cfg           (cfg),
        .pixels_valid  (pixels_valid),
        .weights_valid (weights_valid),
        .run_done      (done),
        .pixels_ready  (pixels_ready),
        .weights_ready (weights_ready),
        .beat          (beat),
        .tag           (tag),
        .run_cfg       (run_cfg),
        .last_col      (last_col)
    );

    conv_mac_array u_mac_array (
        .aclk     (aclk),
        .rst      (rst),
        .beat     (beat),
        .tag      (tag),
        .last_col (last_col),
        .run_cfg  (run_cfg),
        .pixels   (pixels),
        .weights  (weights),
        .acc      (acc)
    );

    // run_done doubles as the external done pulse.
    conv_output_stage u_output_stage (
        .aclk     (aclk),
        .rst      (rst),
        .acc      (acc),
        .run_cfg  (run_cfg),
        .m_valid  (m_valid),
        .m_data   (m_data),
        .m_last   (m_last),
        .run_done (done)
    );

endmodule

`default_nettype wire

// File: logic/conv_mac_array.sv
`timescale 1ns/100ps
`default_nettype none

`include "conv_settings.svh"

module conv_mac_array (
    input  wire                       aclk,
    input  wire                       rst,
    input  wire                       beat,
    input  wire conv_pkg::beat_tag_t  tag,
    input  wire                       last_col,
    input  wire conv_pkg::conv_cfg_t  run_cfg,
    input  wire conv_pkg::pixel_beat_t pixels,
    input  wire conv_pkg::weight_beat_t weights,
    output conv_pkg::acc_vec_t        acc
);

    import conv_pkg::*;

    typedef logic signed [2*`DATA_WIDTH-1:0] prod_t;

    pixel_beat_t            pix_q;
    weight_beat_t           wgt_q;
    beat_tag_t              s0_tag;
    logic                   s0_valid;
    logic                   s0_last;
    prod_t                  prod [`CONV_UNITS][3];
    beat_tag_t              s1_tag;
    logic                   s1_valid;
    logic                   s1_last;
    acc_t                   term [`CONV_UNITS];
    acc_t [`CONV_UNITS-1:0] acc_sum;
    logic                   acc_valid;
    logic                   acc_last;

    function automatic data_t max3(input data_t a, input data_t b, input data_t c);
        data_t m;
        m = a;
        if (b > m) m = b;
        if (c > m) m = c;
        return m;
    endfunction

    always_ff @(posedge aclk) begin
        if (rst) begin
            s0_valid  <= 1'b0;
            s1_valid  <= 1'b0;
            acc_valid <= 1'b0;
            acc_last  <= 1'b0;
        end else begin
            s0_valid  <= beat;
            s1_valid  <= s0_valid;
            acc_valid <= s1_valid && s1_tag.final_beat;
            acc_last  <= s1_valid && s1_tag.final_beat && s1_last;
        end
    end

    // Input capture at acceptance.
    always_ff @(posedge aclk) begin
        if (beat) begin
            pix_q   <= pixels;
            wgt_q   <= weights;
            s0_tag  <= tag;
            s0_last <= last_col;
        end
    end

    // Product stage.
    always_ff @(posedge aclk) begin
        if (s0_valid) begin
            s1_tag  <= s0_tag;
            s1_last <= s0_last;
            for (int u = 0; u < `CONV_UNITS; u++) begin
                prod[u][1] <= '0;
                prod[u][2] <= '0;
                if (run_cfg.is_max) begin
                    if (run_cfg.is_1x1) begin
                        prod[u][0] <= pix_q.row[u+1];
                    end else begin
                        prod[u][0] <= max3(pix_q.row[u], pix_q.row[u+1], pix_q.row[u+2]);
                    end
                end else if (run_cfg.is_1x1) begin
                    prod[u][0] <= '0;
                    prod[u][1] <= pix_q.row[u+1] * wgt_q.w[1];
                end else begin
                    for (int k = 0; k < 3; k++) begin
                        prod[u][k] <= pix_q.row[u+k] * wgt_q.w[k];
                    end
                end
            end
        end
    end

    // Max values go up by the fraction bits so the output shift is uniform.
    always_comb begin
        for (int u = 0; u < `CONV_UNITS; u++) begin
            if (run_cfg.is_max) begin
                term[u] = acc_t'(prod[u][0]) <<< `FRAC_BITS;
            end else begin
                term[u] = acc_t'(prod[u][0]) + acc_t'(prod[u][1]) + acc_t'(prod[u][2]);
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (s1_valid) begin
            for (int u = 0; u < `CONV_UNITS; u++) begin
                if (s1_tag.first) begin
                    acc_sum[u] <= term[u];
                end else if (run_cfg.is_max) begin
                    acc_sum[u] <= (term[u] > acc_sum[u]) ? term[u] : acc_sum[u];
                end else begin
                    acc_sum[u] <= acc_sum[u] + term[u];
                end
            end
        end
    end

    assign acc = '{valid: acc_valid, last: acc_last, sum: acc_sum};

endmodule

`default_nettype wire

// File: logic/conv_output_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "conv_settings.svh"

module conv_output_stage (
    input  wire                        aclk,
    input  wire                        rst,
    input  wire conv_pkg::acc_vec_t    acc,
    input  wire conv_pkg::conv_cfg_t   run_cfg,
    output logic                       m_valid,
    output conv_pkg::result_vec_t      m_data,
    output logic                       m_last,
    output logic                       run_done
);

    import conv_pkg::*;

    localparam data_t WORD_MAX = {1'b0, {(`DATA_WIDTH-1){1'b1}}};
    localparam data_t WORD_MIN = {1'b1, {(`DATA_WIDTH-1){1'b0}}};

    result_vec_t clamped;

    always_comb begin
        acc_t shifted;
        for (int u = 0; u < `CONV_UNITS; u++) begin
            shifted = acc.sum[u] >>> `FRAC_BITS;
            if (shifted > acc_t'(WORD_MAX)) begin
                clamped.word[u] = WORD_MAX;
            end else if (shifted < acc_t'(WORD_MIN)) begin
                clamped.word[u] = WORD_MIN;
            end else begin
                clamped.word[u] = shifted[`DATA_WIDTH-1:0];
            end
            // ReLU.
            if (run_cfg.is_relu && clamped.word[u][`DATA_WIDTH-1]) begin
                clamped.word[u] = '0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            m_valid  <= 1'b0;
            m_last   <= 1'b0;
            run_done <= 1'b0;
        end else begin
            m_valid  <= acc.valid;
            m_last   <= acc.last;
            run_done <= m_valid && m_last;
        end
    end

    always_ff @(posedge aclk) begin
        if (acc.valid) m_data <= clamped;
    end

    a_last_with_valid: assert property (@(posedge aclk) disable iff (rst)
        m_last |-> m_valid)
        else $error("m_last without m_valid");

    // Nothing follows the final vector of a run.
    a_quiet_after_last: assert property (@(posedge aclk) disable iff (rst)
        (m_valid && m_last) |=> !m_valid)
        else $error("m_valid right after m_last");

endmodule

`default_nettype wire

// File: logic/conv_pkg.sv
`default_nettype none

`include "conv_settings.svh"

package conv_pkg;

    typedef logic signed [`DATA_WIDTH-1:0] data_t;
    typedef logic signed [`ACC_WIDTH-1:0]  acc_t;

    // Run configuration latched on start.
    typedef struct packed {
        logic                   is_1x1;
        logic                   is_max;
        logic                   is_relu;
        logic [`COLS_WIDTH-1:0] cols_1;
        logic [`CIN_WIDTH-1:0]  cin_1;
    } conv_cfg_t;

    // One input column of one channel with two halo rows.
    typedef struct packed {
        data_t [`CONV_UNITS+1:0] row;
    } pixel_beat_t;

    // One kernel column.
    typedef struct packed {
        data_t [2:0] w;
    } weight_beat_t;

    typedef struct packed {
        logic first;
        logic final_beat;
    } beat_tag_t;

    typedef struct packed {
        logic                   valid;
        logic                   last;
        acc_t [`CONV_UNITS-1:0] sum;
    } acc_vec_t;

    typedef struct packed {
        data_t [`CONV_UNITS-1:0] word;
    } result_vec_t;

endpackage

`default_nettype wire

// File: logic/conv_settings.svh
`ifndef CONV_SETTINGS_SVH
`define CONV_SETTINGS_SVH

// Output rows computed in parallel.
`define CONV_UNITS 4

// Pixel, weight and result word width.
`define DATA_WIDTH 16

// Q8.8 fixed point.
`define FRAC_BITS 8

// Wide enough for many channels of full scale products.
`define ACC_WIDTH 40

// Input channel and output column counters.
`define CIN_WIDTH 8
`define COLS_WIDTH 8

`endif

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module conv_engine_tb \
    -f conv_engine.f -o conv_engine_sim > build.log 2>&1 \
    && ./obj_dir/conv_engine_sim | tee sim.log \
    || echo "build or simulation did not complete, see build.log"
grep -q "Simulation completed successfully" sim.log 2>/dev/null \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

// File: testbench/conv_engine_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "conv_settings.svh"

module conv_engine_tb;

    import conv_pkg::*;

    localparam int UNITS   = `CONV_UNITS;
    localparam int TIMEOUT = 200;

    typedef struct packed {
        logic        last;
        result_vec_t data;
    } expect_t;

    logic         aclk;
    logic         rst;
    logic         start;
    conv_cfg_t    cfg;
    logic         pixels_valid;
    pixel_beat_t  pixels;
    logic         pixels_ready;
    logic         weights_valid;
    weight_beat_t weights;
    logic         weights_ready;
    logic         m_valid;
    result_vec_t  m_data;
    logic         m_last;
    logic         done;

    logic [31:0]  lfsr = 32'hdf30b4e6;
    expect_t      exp_q[$];
    expect_t      head;
    logic         head_ok = 1'b0;
    logic         started = 1'b0;
    logic         cur_is_max = 1'b0;
    logic         hung = 1'b0;
    int           vectors = 0;
    int           errors = 0;
    int           tests = 0;
    int           failed = 0;

    tb_clock_gen #(.PERIOD_NS(40)) u_clock (.aclk(aclk));

    conv_engine UUT (
        .aclk          (aclk),
        .rst           (rst),
        .start         (start),
        .cfg           (cfg),
        .pixels_valid  (pixels_valid),
        .pixels        (pixels),
        .pixels_ready  (pixels_ready),
        .weights_valid (weights_valid),
        .weights       (weights),
        .weights_ready (weights_ready),
        .m_valid       (m_valid),
        .m_data        (m_data),
        .m_last        (m_last),
        .done          (done)
    );

    // Galois LFSR stepped once per bit taken.
    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[14:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hd0000001) : (lfsr >> 1);
        end
        return v;
    endfunction

    // Roughly -1.0 to +1.0 in Q8.8.
    function automatic data_t small_word();
        logic [15:0] bits;
        bits = take_bits(9);
        return data_t'($signed(bits[8:0]));
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests++;
        if (errors != errors_before) begin
            failed++;
        end
        $display("test %-12s %s", name, (errors == errors_before) ? "passed" : "FAILED");
    endtask

    task automatic run_case(input string name, input logic is_1x1, input logic is_max,
                            input logic is_relu, input int cols, input int cin,
                            input int bias, input logic big);
        pixel_beat_t  pix_beats[$];
        weight_beat_t wgt_beats[$];
        pixel_beat_t  pb;
        weight_beat_t wb;
        expect_t      ev;
        longint       sums[UNITS];
        longint       win;
        int           bpc;
        int           errors_before;
        int           waited;
        logic         accepted;
        logic         seen;

        if (hung) begin
            return;
        end
        bpc = is_1x1 ? 1 : 3;
        errors_before = errors;
        // Reference results with one vector per output column.
        for (int c = 0; c < cols; c++) begin
            for (int u = 0; u < UNITS; u++) begin
                sums[u] = is_max ? -64'sd65536 : 64'sd0;
            end
            for (int n = 0; n < cin * bpc; n++) begin
                for (int r = 0; r < UNITS + 2; r++) begin
                    pb.row[r] = big ? 16'sh7f00 : data_t'(small_word() - bias);
                end
                for (int j = 0; j < 3; j++) begin
                    wb.w[j] = big ? (((c % 2) == 1) ? 16'sh8100 : 16'sh7f00) : small_word();
                end
                pix_beats.push_back(pb);
                wgt_beats.push_back(wb);
                for (int u = 0; u < UNITS; u++) begin
                    if (is_max) begin
                        win = pb.row[u + 1];
                        if (!is_1x1 && pb.row[u] > win) begin
                            win = pb.row[u];
                        end
                        if (!is_1x1 && pb.row[u + 2] > win) begin
                            win = pb.row[u + 2];
                        end
                        sums[u] = (win > sums[u]) ? win : sums[u];
                    end else if (is_1x1) begin
                        sums[u] += longint'(pb.row[u + 1]) * longint'(wb.w[1]);
                    end else begin
                        for (int j = 0; j < 3; j++) begin
                            sums[u] += longint'(pb.row[u + j]) * longint'(wb.w[j]);
                        end
                    end
                end
            end
            for (int u = 0; u < UNITS; u++) begin
                win = is_max ? sums[u] : (sums[u] >>> `FRAC_BITS);
                win = (win > 32767) ? 32767 : ((win < -32768) ? -32768 : win);
                if (is_relu && win < 0) begin
                    win = 0;
                end
                ev.data.word[u] = data_t'(win);
            end
            ev.last = (c == cols - 1);
            exp_q.push_back(ev);
        end

        vectors     = 0;
        cfg.is_1x1  = is_1x1;
        cfg.is_max  = is_max;
        cfg.is_relu = is_relu;
        cfg.cols_1  = `COLS_WIDTH'(cols - 1);
        cfg.cin_1   = `CIN_WIDTH'(cin - 1);
        cur_is_max  = is_max;
        start       = 1'b1;
        started     = 1'b1;
        @(posedge aclk);
        #1;
        start = 1'b0;
        for (int b = 0; b < pix_beats.size() && !hung; b++) begin
            if (take_bits(1) == 1) begin
                pixels_valid  = 1'b0;
                weights_valid = 1'b0;
                @(posedge aclk);
                #1;
            end
            pixels        = pix_beats[b];
            weights       = wgt_beats[b];
            pixels_valid  = 1'b1;
            weights_valid = !is_max;
            waited        = 0;
            do begin
                @(negedge aclk);
                accepted = pixels_ready;
                @(posedge aclk);
                #1;
                waited++;
            end while (!accepted && waited < TIMEOUT);
            if (!accepted) begin
                $display("test %s: beat %0d was never accepted", name, b);
                hung = 1'b1;
                errors++;
            end
        end
        pixels_valid  = 1'b0;
        weights_valid = 1'b0;

        waited = 0;
        seen   = 1'b0;
        while (!hung && !seen && waited < TIMEOUT) begin
            @(negedge aclk);
            seen = done;
            waited++;
        end
        if (!hung && !seen) begin
            $display("test %s: done never pulsed", name);
            hung = 1'b1;
            errors++;
        end
        if (!hung && (vectors != cols || exp_q.size() != 0)) begin
            $display("test %s: %0d result vectors for %0d columns", name, vectors, cols);
            errors++;
        end
        report_test(name, errors_before);
        repeat (3) @(posedge aclk);
        #1;
    endtask

    // Pops the next expected vector while m_valid is stable.
    always @(negedge aclk) begin
        if (m_valid) begin
            head_ok = (exp_q.size() != 0);
            if (head_ok) begin
                head = exp_q.pop_front();
            end
            vectors++;
        end
    end

    a_quiet_before_start: assert property (@(posedge aclk) disable iff (rst)
        !started |-> !(pixels_ready || weights_ready || m_valid || m_last || done))
        else begin
            $display("outputs active before the first start");
            errors++;
        end

    a_vector_expected: assert property (@(posedge aclk) disable iff (rst)
        m_valid |-> head_ok)
        else begin
            $display("result vector with no column left to expect");
            errors++;
        end

    a_data_match: assert property (@(posedge aclk) disable iff (rst)
        (m_valid && head_ok) |-> (m_data == head.data))
        else begin
            $display("ERR m_data expected %h got %h", $sampled(head.data), $sampled(m_data));
            errors++;
        end

    a_last_match: assert property (@(posedge aclk) disable iff (rst)
        (m_valid && head_ok) |-> (m_last == head.last))
        else begin
            $display("ERR m_last expected %h got %h", $sampled(head.last), $sampled(m_last));
            errors++;
        end

    a_done_after_last: assert property (@(posedge aclk) disable iff (rst)
        (m_valid && m_last) |=> done)
        else begin
            $display("done missing one cycle after the final vector");
            errors++;
        end

    a_done_only_after_last: assert property (@(posedge aclk) disable iff (rst)
        done |-> $past(m_valid && m_last))
        else begin
            $display("done pulsed without a final vector just before it");
            errors++;
        end

    // Equal to pixels_ready in conv mode and low in max mode.
    a_weights_ready_match: assert property (@(posedge aclk) disable iff (rst)
        weights_ready == (pixels_ready && !cur_is_max))
        else begin
            $display("ERR weights_ready expected %h got %h",
                     $sampled(pixels_ready && !cur_is_max), $sampled(weights_ready));
            errors++;
        end

    initial begin
        #2000000;
        abort_run("watchdog expired, the run hung");
    end

    initial begin
        rst           = 1'b1;
        start         = 1'b0;
        cfg           = '0;
        pixels_valid  = 1'b0;
        pixels        = '0;
        weights_valid = 1'b0;
        weights       = '0;
        repeat (16) @(posedge aclk);
        #1;
        rst = 1'b0;
        repeat (8) @(posedge aclk);
        #1;
        report_test("reset_idle", 0);
        run_case("conv3x3", 1'b0, 1'b0, 1'b0, 5, 3, 0, 1'b0);
        run_case("conv1x1", 1'b1, 1'b0, 1'b0, 4, 4, 0, 1'b0);
        run_case("max_relu", 1'b0, 1'b1, 1'b1, 4, 1, 200, 1'b0);
        run_case("one_column", 1'b0, 1'b0, 1'b1, 1, 2, 0, 1'b0);
        run_case("saturate", 1'b0, 1'b0, 1'b0, 2, 3, 0, 1'b1);
        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            abort_run("one or more checks failed");
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 40
) (
    output logic aclk
);

    initial begin
        aclk = 1'b0;
    end

    // Free running, low for the first half period.
    always #(PERIOD_NS / 2) aclk = ~aclk;

endmodule

`default_nettype wire
